// File: src/pc_pkg.sv
package pc_pkg;

  // width of the code address
  localparam int unsigned addr_w = 16;

  // width of the data bus
  localparam int unsigned data_w = 8;

  // extra bits above a data byte once it is widened to a code address
  localparam int unsigned ext_w = addr_w - data_w;

  // program counter value after reset
  localparam logic [addr_w-1:0] pc_rst_val = '0;

  // fetch address opcodes
  // only the three jump types produce a target
  typedef enum logic [2:0] {
    // idle command, the pc just counts or holds
    pc_op_nop        = 3'd0,
    // stage a high byte for a later far jump
    pc_op_load_tmp   = 3'd1,
    // new low byte, high byte unchanged
    pc_op_jump_lo    = 3'd2,
    // staged high byte with the data byte as low byte
    pc_op_jump_far   = 3'd3,
    // pc plus the signed data byte
    pc_op_branch_rel = 3'd4
  } pc_op_e;

  // jump conditions, tested against the stored alu flags
  typedef enum logic [2:0] {
    cond_always    = 3'd0,
    cond_zero      = 3'd1,
    cond_not_zero  = 3'd2,
    cond_carry     = 3'd3,
    cond_not_carry = 3'd4,
    cond_negative  = 3'd5
  } pc_cond_e;

  // one command per clock
  // 3 + 3 + 8 = 14 bits
  typedef struct packed {
    pc_op_e            op;
    pc_cond_e          cond;
    logic [data_w-1:0] data;
  } pc_cmd_t;

  // alu flags as written by the datapath
  // overflow is kept but no condition looks at it
  typedef struct packed {
    logic zero;
    logic carry;
    logic negative;
    logic overflow;
  } pc_flags_t;

  // jump address for the current command
  // jump is high only for a jump type opcode
  typedef struct packed {
    logic              jump;
    logic [addr_w-1:0] addr;
  } pc_target_t;

endpackage

// File: src/flag_condition.sv
`timescale 1ns/1ps

module flag_condition
  import pc_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  pc_cond_e  cond,
  input  pc_flags_t flags,
  input  logic      flags_we,
  output logic      taken
);

  // last flags written by the alu
  pc_flags_t flags_q;

  // individual stored flags, named for the condition decode
  logic flag_z;
  logic flag_c;
  logic flag_n;

  // flag register
  // loads on the strobe edge only
  // a command in the same cycle still sees the old value
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      flags_q <= '0;
    end
    else if (flags_we)
    begin
      flags_q <= flags;
    end
  end

  assign flag_z = flags_q.zero;
  assign flag_c = flags_q.carry;
  assign flag_n = flags_q.negative;

  // condition decode
  // purely combinational from cond and the stored flags
  always_comb
  begin
    case (cond)
      cond_always:
      begin
        taken = 1'b1;
      end
      cond_zero:
      begin
        taken = flag_z;
      end
      cond_not_zero:
      begin
        taken = ~flag_z;
      end
      cond_carry:
      begin
        taken = flag_c;
      end
      cond_not_carry:
      begin
        taken = ~flag_c;
      end
      cond_negative:
      begin
        taken = flag_n;
      end
      // unused encodings never jump
      default:
      begin
        taken = 1'b0;
      end
    endcase
  end

endmodule

// File: src/jump_target.sv
`timescale 1ns/1ps

module jump_target
  import pc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  pc_cmd_t           cmd,
  input  logic [addr_w-1:0] pc,
  output pc_target_t        target
);

  // staged high byte for far jumps
  logic [data_w-1:0] tmp_hi;

  // high byte of the current pc
  logic [ext_w-1:0] pc_hi;

  // data byte widened with its sign bit
  logic [addr_w-1:0] rel_ofs;

  // pc plus offset
  // carry out of bit 15 is dropped, so the sum wraps
  logic [addr_w-1:0] rel_addr;

  // temporary high register
  // written by load_tmp whatever the condition field holds
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      tmp_hi <= '0;
    end
    else if (cmd.op == pc_op_load_tmp)
    begin
      tmp_hi <= cmd.data;
    end
  end

  assign pc_hi = pc[addr_w-1:data_w];

  // sign extension of the branch offset
  assign rel_ofs = {{ext_w{cmd.data[data_w-1]}}, cmd.data};

  assign rel_addr = pc + rel_ofs;

  // address forming per opcode
  // non jump opcodes leave jump low and park the address on pc
  always_comb
  begin
    target.jump = 1'b0;
    target.addr = pc;
    case (cmd.op)
      // short jump within the current 256 byte page
      pc_op_jump_lo:
      begin
        target.jump = 1'b1;
        target.addr = {pc_hi, cmd.data};
      end
      // full 16 bit jump
      // high byte must have been staged earlier
      pc_op_jump_far:
      begin
        target.jump = 1'b1;
        target.addr = {tmp_hi, cmd.data};
      end
      // relative to the address of this command
      pc_op_branch_rel:
      begin
        target.jump = 1'b1;
        target.addr = rel_addr;
      end
      // nop and load_tmp
      default:
      begin
        target.jump = 1'b0;
        target.addr = pc;
      end
    endcase
  end

endmodule

// File: src/pc_counter.sv
`timescale 1ns/1ps

module pc_counter
  import pc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              run,
  input  logic              taken,
  input  pc_target_t        target,
  output logic [addr_w-1:0] pc,
  output logic              jumped
);

  // jump opcode with its condition met
  logic load;

  // pc for the next edge
  logic [addr_w-1:0] pc_next;

  // count step
  // wraps from ffff to 0000 on its own
  logic [addr_w-1:0] pc_inc;

  assign load = taken & target.jump;

  assign pc_inc = pc + 1'b1;

  // next pc select
  // a taken jump wins even with run low
  always_comb
  begin
    if (load)
    begin
      pc_next = target.addr;
    end
    else if (run)
    begin
      pc_next = pc_inc;
    end
    else
    begin
      // stalled
      pc_next = pc;
    end
  end

  // pc register and jump pulse
  // both change on the edge that samples the command
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc     <= pc_rst_val;
      jumped <= 1'b0;
    end
    else
    begin
      pc     <= pc_next;
      // high for one cycle after a loaded target
      jumped <= load;
    end
  end

endmodule

// File: src/pc_unit.sv
`timescale 1ns/1ps

module pc_unit
  import pc_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  pc_cmd_t           cmd,
  input  pc_flags_t         flags,
  input  logic              flags_we,
  input  logic              run,
  output logic [addr_w-1:0] pc,
  output logic              jumped
);

  // condition result for the current command
  logic taken;

  // jump address for the current command
  pc_target_t target;

  // flags and condition check
  flag_condition u_flag_condition (
    .clk      (clk),
    .rst      (rst),
    .cond     (cmd.cond),
    .flags    (flags),
    .flags_we (flags_we),
    .taken    (taken)
  );

  // staged high byte and address forming
  // needs the live pc for jump_lo and branch_rel
  jump_target u_jump_target (
    .clk    (clk),
    .rst    (rst),
    .cmd    (cmd),
    .pc     (pc),
    .target (target)
  );

  // the one pc register
  pc_counter u_pc_counter (
    .clk    (clk),
    .rst    (rst),
    .run    (run),
    .taken  (taken),
    .target (target),
    .pc     (pc),
    .jumped (jumped)
  );

endmodule

// File: verif/pc_unit_checker.sv
`timescale 1ns/1ps

module pc_unit_checker
  import pc_pkg::*;
(
  input logic              clk,
  input logic              rst,
  input logic              run,
  input logic              taken,
  input pc_target_t        target,
  input logic [addr_w-1:0] pc,
  input logic              jumped
);

  // jump type opcode with its condition met
  logic load;

  // pc one step ahead
  // wraps at 16 bits
  logic [addr_w-1:0] pc_plus_one;

  assign load = taken & target.jump;

  assign pc_plus_one = pc + 1'b1;

  // pc comes out of reset at zero
  a_reset_zero: assert property (@(posedge clk) rst |=> (pc == 16'h0000))
    else $error("pc is not zero after reset");

  // plain counting while running
  a_count: assert property (@(posedge clk) disable iff (rst)
    (!load && run) |=> (pc == $past(pc_plus_one)))
    else $error("pc did not increment while running");

  // stalled with no jump
  a_hold: assert property (@(posedge clk) disable iff (rst)
    (!load && !run) |=> (pc == $past(pc)))
    else $error("pc moved while run was low");

  // jump pulse one cycle after a loaded target
  a_jump_pulse: assert property (@(posedge clk) disable iff (rst)
    load |=> jumped)
    else $error("jumped missing after a taken jump");

  // and no pulse without one
  a_no_pulse: assert property (@(posedge clk) disable iff (rst)
    !load |=> !jumped)
    else $error("jumped high without a taken jump");

endmodule

// attach to the pc register block
bind pc_counter pc_unit_checker u_pc_unit_checker (
  .clk    (clk),
  .rst    (rst),
  .run    (run),
  .taken  (taken),
  .target (target),
  .pc     (pc),
  .jumped (jumped)
);

// File: verif/pc_unit_tb.sv
`timescale 1ns/1ps

module pc_unit_tb
  import pc_pkg::*;
();

  logic              clk;
  logic              rst;
  pc_cmd_t           cmd;
  pc_flags_t         flags;
  logic              flags_we;
  logic              run;
  logic [addr_w-1:0] pc;
  logic              jumped;

  // stimulus table, one entry per clock
  string             t_name[$];
  pc_cmd_t           t_cmd[$];
  pc_flags_t         t_flags[$];
  logic              t_we[$];
  logic              t_run[$];
  logic [addr_w-1:0] t_pc[$];
  logic              t_jmp[$];

  // reference model state
  logic [addr_w-1:0] m_pc;
  logic [data_w-1:0] m_tmp;
  pc_flags_t         m_flags;

  // random source, galois lfsr
  logic [15:0] lfsr;

  pc_unit UUT (
    .clk      (clk),
    .rst      (rst),
    .cmd      (cmd),
    .flags    (flags),
    .flags_we (flags_we),
    .run      (run),
    .pc       (pc),
    .jumped   (jumped)
  );

  // 4 ns clock
  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // reset for 4 cycles, released on a falling edge
  initial
  begin
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
  end

  function automatic pc_flags_t flags_of(input logic z, input logic c, input logic n,
                                         input logic v);
    pc_flags_t f;
    f.zero     = z;
    f.carry    = c;
    f.negative = n;
    f.overflow = v;
    return f;
  endfunction

  function automatic pc_cmd_t make_cmd(input pc_op_e op, input pc_cond_e cond,
                                       input logic [data_w-1:0] data);
    pc_cmd_t c;
    c.op   = op;
    c.cond = cond;
    c.data = data;
    return c;
  endfunction

  // one lfsr step, taps 0xb400
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    if (s[0])
    begin
      return (s >> 1) ^ 16'hB400;
    end
    return s >> 1;
  endfunction

  // n fresh bits, one step each
  function automatic logic [15:0] rand_bits(input int n);
    logic [15:0] r;
    int          k;
    r = '0;
    for (k = 0; k < n; k++)
    begin
      lfsr = lfsr_next(lfsr);
      r    = {r[14:0], lfsr[0]};
    end
    return r;
  endfunction

  // condition rules
  function automatic logic cond_met(input pc_cond_e cond, input pc_flags_t f);
    case (cond)
      cond_always:    return 1'b1;
      cond_zero:      return f.zero;
      cond_not_zero:  return ~f.zero;
      cond_carry:     return f.carry;
      cond_not_carry: return ~f.carry;
      cond_negative:  return f.negative;
      default:        return 1'b0;
    endcase
  endfunction

  task automatic add_entry(input string name, input pc_op_e op, input pc_cond_e cond,
                           input logic [data_w-1:0] data, input pc_flags_t f,
                           input logic we, input logic r,
                           input logic [addr_w-1:0] exp_pc, input logic exp_j);
    t_name.push_back(name);
    t_cmd.push_back(make_cmd(op, cond, data));
    t_flags.push_back(f);
    t_we.push_back(we);
    t_run.push_back(r);
    t_pc.push_back(exp_pc);
    t_jmp.push_back(exp_j);
  endtask

  task automatic check_value(input string name, input logic [addr_w-1:0] exp,
                             input logic [addr_w-1:0] act);
    assert (act === exp)
    else
    begin
      $display("Mismatch %s expected %h actual %h", name, exp, act);
      $display("TESTS FAILED");
      $fatal(1);
    end
  endtask

  task automatic build_table();
    pc_flags_t nf;
    pc_flags_t zf;
    pc_flags_t cnf;
    nf  = flags_of(1'b0, 1'b0, 1'b0, 1'b0);
    zf  = flags_of(1'b1, 1'b0, 1'b0, 1'b0);
    cnf = flags_of(1'b0, 1'b1, 1'b1, 1'b0);
    // counting, holding and the wrap
    add_entry("count_1", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'h0001, 1'b0);
    add_entry("count_2", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'h0002, 1'b0);
    add_entry("hold_1", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b0, 16'h0002, 1'b0);
    add_entry("hold_2", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b0, 16'h0002, 1'b0);
    add_entry("count_3", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'h0003, 1'b0);
    add_entry("stage_ff", pc_op_load_tmp, cond_always, 8'hFF, nf, 1'b0, 1'b0, 16'h0003, 1'b0);
    add_entry("far_fffe", pc_op_jump_far, cond_always, 8'hFE, nf, 1'b0, 1'b1, 16'hFFFE, 1'b1);
    add_entry("count_ffff", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'hFFFF, 1'b0);
    add_entry("wrap_0000", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'h0000, 1'b0);
    // staged far jump
    add_entry("stage_12", pc_op_load_tmp, cond_always, 8'h12, nf, 1'b0, 1'b1, 16'h0001, 1'b0);
    add_entry("far_1234", pc_op_jump_far, cond_always, 8'h34, nf, 1'b0, 1'b1, 16'h1234, 1'b1);
    add_entry("count_1235", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b1, 16'h1235, 1'b0);
    // page jump and relative branches
    add_entry("jump_lo_80", pc_op_jump_lo, cond_always, 8'h80, nf, 1'b0, 1'b1, 16'h1280, 1'b1);
    add_entry("rel_pos", pc_op_branch_rel, cond_always, 8'h10, nf, 1'b0, 1'b1, 16'h1290, 1'b1);
    add_entry("rel_neg", pc_op_branch_rel, cond_always, 8'hF0, nf, 1'b0, 1'b1, 16'h1280, 1'b1);
    add_entry("stage_00", pc_op_load_tmp, cond_always, 8'h00, nf, 1'b0, 1'b0, 16'h1280, 1'b0);
    add_entry("far_0005", pc_op_jump_far, cond_always, 8'h05, nf, 1'b0, 1'b1, 16'h0005, 1'b1);
    add_entry("rel_wrap_dn", pc_op_branch_rel, cond_always, 8'hF0, nf, 1'b0, 1'b1, 16'hFFF5, 1'b1);
    add_entry("rel_wrap_up", pc_op_branch_rel, cond_always, 8'h20, nf, 1'b0, 1'b1, 16'h0015, 1'b1);
    // conditions against stored flags, zero set
    add_entry("write_z", pc_op_nop, cond_always, 8'h00, zf, 1'b1, 1'b1, 16'h0016, 1'b0);
    add_entry("jz_taken", pc_op_jump_lo, cond_zero, 8'h40, nf, 1'b0, 1'b1, 16'h0040, 1'b1);
    add_entry("jnz_fall", pc_op_jump_lo, cond_not_zero, 8'h80, nf, 1'b0, 1'b1, 16'h0041, 1'b0);
    add_entry("jc_fall", pc_op_jump_lo, cond_carry, 8'h80, nf, 1'b0, 1'b1, 16'h0042, 1'b0);
    add_entry("jnc_taken", pc_op_jump_lo, cond_not_carry, 8'h60, nf, 1'b0, 1'b1, 16'h0060, 1'b1);
    add_entry("jn_fall", pc_op_jump_lo, cond_negative, 8'h80, nf, 1'b0, 1'b1, 16'h0061, 1'b0);
    // write in the jump cycle is seen one cycle late
    add_entry("jc_same_wr", pc_op_jump_lo, cond_carry, 8'h90, cnf, 1'b1, 1'b1, 16'h0062, 1'b0);
    add_entry("jc_taken", pc_op_jump_lo, cond_carry, 8'h90, nf, 1'b0, 1'b1, 16'h0090, 1'b1);
    add_entry("jn_taken", pc_op_branch_rel, cond_negative, 8'h08, nf, 1'b0, 1'b1, 16'h0098, 1'b1);
    add_entry("jz_fall", pc_op_jump_lo, cond_zero, 8'h00, nf, 1'b0, 1'b1, 16'h0099, 1'b0);
    add_entry("jnz_taken", pc_op_jump_lo, cond_not_zero, 8'hA0, nf, 1'b0, 1'b1, 16'h00A0, 1'b1);
    add_entry("jnc_fall", pc_op_jump_lo, cond_not_carry, 8'h00, nf, 1'b0, 1'b1, 16'h00A1, 1'b0);
    // jumps with run low
    add_entry("jump_run_lo", pc_op_jump_lo, cond_always, 8'hC0, nf, 1'b0, 1'b0, 16'h00C0, 1'b1);
    add_entry("hold_run_lo", pc_op_nop, cond_always, 8'h00, nf, 1'b0, 1'b0, 16'h00C0, 1'b0);
    add_entry("fall_run_lo", pc_op_jump_lo, cond_zero, 8'h00, nf, 1'b0, 1'b0, 16'h00C0, 1'b0);
  endtask

  // random commands against the model
  task automatic run_random(input int count);
    pc_cmd_t           c;
    pc_flags_t         f;
    logic              we;
    logic              r;
    logic [15:0]       bits;
    logic              jmp;
    logic [addr_w-1:0] tgt;
    logic [addr_w-1:0] exp_pc;
    int                i;
    for (i = 0; i < count; i++)
    begin
      bits = rand_bits(3);
      case (bits[2:0])
        3'd1:    c.op = pc_op_load_tmp;
        3'd2:    c.op = pc_op_jump_lo;
        3'd3:    c.op = pc_op_jump_far;
        3'd4:    c.op = pc_op_branch_rel;
        default: c.op = pc_op_nop;
      endcase
      bits = rand_bits(3);
      case (bits[2:0])
        3'd1:    c.cond = cond_zero;
        3'd2:    c.cond = cond_not_zero;
        3'd3:    c.cond = cond_carry;
        3'd4:    c.cond = cond_not_carry;
        3'd5:    c.cond = cond_negative;
        default: c.cond = cond_always;
      endcase
      bits   = rand_bits(8);
      c.data = bits[7:0];
      bits   = rand_bits(4);
      f      = bits[3:0];
      bits   = rand_bits(1);
      we     = bits[0];
      // run high three times out of four
      bits   = rand_bits(2);
      r      = (bits[1:0] != 2'b00);
      // target per opcode rules
      jmp = 1'b1;
      tgt = m_pc;
      case (c.op)
        pc_op_jump_lo:    tgt = {m_pc[15:8], c.data};
        pc_op_jump_far:   tgt = {m_tmp, c.data};
        pc_op_branch_rel: tgt = m_pc + {{8{c.data[7]}}, c.data};
        default:          jmp = 1'b0;
      endcase
      jmp = jmp & cond_met(c.cond, m_flags);
      if (jmp)
      begin
        exp_pc = tgt;
      end
      else if (r)
      begin
        exp_pc = m_pc + 16'd1;
      end
      else
      begin
        exp_pc = m_pc;
      end
      if (c.op == pc_op_load_tmp)
      begin
        m_tmp = c.data;
      end
      if (we)
      begin
        m_flags = f;
      end
      m_pc = exp_pc;
      // drive, let the edge pass, check on the next falling edge
      cmd      = c;
      flags    = f;
      flags_we = we;
      run      = r;
      @(posedge clk);
      @(negedge clk);
      check_value($sformatf("random_%0d_pc", i), exp_pc, pc);
      check_value($sformatf("random_%0d_jumped", i), {15'd0, jmp}, {15'd0, jumped});
    end
  endtask

  initial
  begin
    int n;
    int i;
    cmd      = make_cmd(pc_op_nop, cond_always, 8'h00);
    flags    = flags_of(1'b0, 1'b0, 1'b0, 1'b0);
    flags_we = 1'b0;
    run      = 1'b0;
    lfsr     = 16'd20;
    build_table();

    // wait out reset
    n = 0;
    @(posedge clk);
    while (rst && n < 50)
    begin
      @(posedge clk);
      n++;
    end
    if (rst)
    begin
      $display("reset never released within 50 cycles");
      $display("TESTS FAILED");
      $fatal(1);
    end
    @(negedge clk);
    check_value("reset_pc", 16'h0000, pc);
    check_value("reset_jumped", 16'h0000, {15'd0, jumped});

    // directed table
    for (i = 0; i < t_name.size(); i++)
    begin
      cmd      = t_cmd[i];
      flags    = t_flags[i];
      flags_we = t_we[i];
      run      = t_run[i];
      @(posedge clk);
      @(negedge clk);
      check_value({t_name[i], "_pc"}, t_pc[i], pc);
      check_value({t_name[i], "_jumped"}, {15'd0, t_jmp[i]}, {15'd0, jumped});
    end

    // model picks up where the table left off
    m_pc    = t_pc[t_pc.size() - 1];
    m_tmp   = 8'h00;
    m_flags = flags_of(1'b0, 1'b1, 1'b1, 1'b0);
    run_random(300);

    cmd      = make_cmd(pc_op_nop, cond_always, 8'h00);
    flags_we = 1'b0;
    run      = 1'b0;
    @(negedge clk);
    $display("TESTS PASSED");
    $finish;
  end

endmodule

// File: tb.f
src/pc_pkg.sv
src/flag_condition.sv
src/jump_target.sv
src/pc_counter.sv
src/pc_unit.sv
verif/pc_unit_checker.sv
verif/pc_unit_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pc_unit testbench with verilator
# exit status follows the pass message in sim.log

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --assert --top-module pc_unit_tb -f tb.f -o pc_unit_sim \
  > build.log 2>&1 \
  && ./obj_dir/pc_unit_sim > sim.log 2>&1 \
  || cat build.log sim.log 2>/dev/null

grep -qs "TESTS PASSED" sim.log && echo "simulation passed" && exit 0 \
  || echo "simulation failed" && exit 1
